// ==== include/rv_macros.svh ====
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

`define RV_XLEN     32
`define RV_REG_AW   5
`define RV_RESET_PC 32'h0000_0000
// Major opcodes
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_OP_IMM 7'b0010011
`define RV_OP_OP     7'b0110011
`define RV_OP_SYSTEM 7'b1110011
`define RV_F3_ADD 3'b000
`define RV_F3_SLL 3'b001
`define RV_F3_W   3'b010 // Only LW and SW are decoded
`define RV_F3_SR  3'b101
// ALU codes are {funct7[5], funct3}
`define RV_ALU_ADD  4'b0000
`define RV_ALU_SLL  4'b0001
`define RV_ALU_SLT  4'b0010
`define RV_ALU_SLTU 4'b0011
`define RV_ALU_XOR  4'b0100
`define RV_ALU_SRL  4'b0101
`define RV_ALU_OR   4'b0110
`define RV_ALU_AND  4'b0111
`define RV_ALU_SUB  4'b1000
`define RV_ALU_SRA  4'b1101

`endif

// ==== project.f ====
+incdir+include
verilog/rv_pkg.sv
verilog/rv_decode_if.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_sequencer.sv
verilog/rv_core.sv
tb/rv_core_assert.sv
tb/rv_core_tb.sv

// ==== tb/rv_core_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_assert (
  input logic        clk,
  input logic        rst,
  input logic        wb_cyc,
  input logic        wb_stb,
  input logic        wb_we,
  input logic [31:0] wb_adr,
  input logic [31:0] wb_wdata,
  input logic        wb_ack,
  input logic        halt
);

  int fails = 0; // Read back by the testbench

  stb_in_cycle: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
    else begin
      fails++;
      $error("wb_stb high outside a bus cycle");
    end

  // Request payload frozen until the slave answers
  payload_held: assert property (@(posedge clk) disable iff (rst)
    wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_we) && (!wb_we || $stable(wb_wdata)))
    else begin
      fails++;
      $error("Bus address, direction or write data changed during a wait state");
    end

  halt_idle: assert property (@(posedge clk) disable iff (rst) halt |-> !wb_cyc)
    else begin
      fails++;
      $error("Bus cycle active while halted");
    end

  drop_after_ack: assert property (@(posedge clk) disable iff (rst)
    wb_cyc && wb_ack |=> !wb_cyc && !wb_stb)
    else begin
      fails++;
      $error("wb_cyc or wb_stb still high in the cycle after ack");
    end

endmodule

`default_nettype wire

// ==== tb/rv_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_macros.svh"

module rv_core_tb;

  localparam int         mem_words  = 128;  // 512 bytes from address 0
  localparam logic [3:0] rec_code   = 4'hC; // Program or preloaded data word
  localparam logic [3:0] rec_store  = 4'hD; // Expected bus write, in order
  localparam logic [3:0] rec_end    = 4'hE;
  localparam int         halt_limit = 3000; // Cycles for the whole program
  localparam int         quiet_span = 20;

  logic        clk, rst;
  logic        wb_cyc, wb_stb, wb_we, halt;
  logic        wb_ack = 1'b0;
  logic [31:0] wb_adr, wb_wdata;
  logic [31:0] wb_rdata = '0;

  logic [31:0] mem [mem_words];
  logic        valid [mem_words]; // Loaded from the trace or written by the core
  logic [31:0] exp_adr [$];
  logic [31:0] exp_dat [$];
  integer      seed;
  int          value_errors, other_errors;
  int          wait_left = 0;
  logic        busy = 1'b0;
  logic        first_access;

  rv_core u_rv_core (.*);

  bind rv_core rv_core_assert u_core_assert (.*);

  always #5 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      value_errors++;
      $display("ERROR %0t %s actual %h expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic load_trace();
    int               fd, n;
    logic [3:0]       kind;
    logic [31:0]      adr, dat;
    logic [8*100-1:0] line;
    logic             done;
    done = 1'b0;
    for (int i = 0; i < mem_words; i++) begin
      mem[i]   = 32'hDEAD_0000 | (i * 4);
      valid[i] = 1'b0;
    end
    fd = $fopen("tb/rv_program_trace.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("Cannot open the trace file tb/rv_program_trace.txt");
    end else begin
      while (!done && !$feof(fd)) begin
        line = '0;
        n = $fgets(line, fd);
        n = $sscanf(line, "%h %h %h", kind, adr, dat); // Comment lines give 0
        if (n >= 1 && kind == rec_end) begin
          done = 1'b1;
        end else if (n == 3 && kind == rec_code) begin
          mem[adr[8:2]]   = dat;
          valid[adr[8:2]] = 1'b1;
        end else if (n == 3 && kind == rec_store) begin
          exp_adr.push_back(adr);
          exp_dat.push_back(dat);
        end
      end
      $fclose(fd);
      if (!done) begin
        other_errors++;
        $display("The trace file ends without its end record");
      end
    end
  endtask

  // One finished bus cycle, seen by the slave
  task automatic serve_access();
    logic [6:0] idx;
    idx = wb_adr[8:2];
    if (first_access) begin
      check_value("wb_adr", wb_adr, `RV_RESET_PC);
      first_access = 1'b0;
    end
    if (wb_adr[1:0] != 2'b00 || wb_adr >= mem_words * 4) begin
      other_errors++;
      $display("Bus access to %h is misaligned or outside memory", wb_adr);
    end else if (wb_we) begin
      mem[idx]   = wb_wdata;
      valid[idx] = 1'b1;
      if (exp_adr.size() == 0) begin
        other_errors++;
        $display("Extra store of %h to %h after the last expected one", wb_wdata, wb_adr);
      end else begin
        check_value("wb_adr", wb_adr, exp_adr.pop_front());
        check_value("wb_wdata", wb_wdata, exp_dat.pop_front());
      end
    end else begin
      if (!valid[idx]) begin
        other_errors++;
        $display("Read from %h hits a word that was never loaded or written", wb_adr);
      end
      wb_rdata <= mem[idx];
    end
  endtask

  // Slave, 0 to 3 wait states per access
  always @(negedge clk) begin
    if (rst) begin
      wb_ack <= 1'b0;
      busy = 1'b0;
    end else if (wb_ack) begin
      wb_ack <= 1'b0; // Single-cycle ack
      busy = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!busy) begin
        busy = 1'b1;
        wait_left = $random(seed) & 3;
      end
      if (wait_left == 0) begin
        serve_access();
        wb_ack <= 1'b1;
      end else begin
        wait_left--;
      end
    end
  end

  initial begin
    int cycles;
    clk          = 1'b0;
    rst          = 1'b1;
    seed         = 32'h233f_6ffe;
    value_errors = 0;
    other_errors = 0;
    first_access = 1'b1;
    load_trace();
    repeat (16) begin
      @(negedge clk);
      check_value("wb_cyc", wb_cyc, 1'b0);
      check_value("wb_stb", wb_stb, 1'b0);
      check_value("wb_we", wb_we, 1'b0);
      check_value("halt", halt, 1'b0);
    end
    rst = 1'b0;
    cycles = 0;
    while (!halt && cycles < halt_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!halt) begin
      other_errors++;
      $display("Timeout: halt did not rise within %0d cycles", halt_limit);
    end
    if (exp_adr.size() != 0) begin
      other_errors++;
      $display("Run ended with %0d expected stores never seen", exp_adr.size());
    end
    repeat (quiet_span) begin
      @(negedge clk);
      check_value("wb_cyc", wb_cyc, 1'b0);
      check_value("halt", halt, 1'b1);
    end
    $display("Run complete: %0d value errors, %0d other errors, %0d assertion failures",
             value_errors, other_errors, u_rv_core.u_core_assert.fails);
    if (value_errors == 0 && other_errors == 0 && u_rv_core.u_core_assert.fails == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/rv_program_trace.txt ====
# Columns: record (C program or data word, D expected store, E end), address, data
# Text after the third column names the instruction or the value
C 00000000 10000093 addi x1, x0, 0x100
C 00000004 ff900113 addi x2, x0, -7
C 00000008 00500193 addi x3, x0, 5
C 0000000c 00310233 add  x4, x2, x3
C 00000010 0040a023 sw   x4, 0(x1)
C 00000014 402182b3 sub  x5, x3, x2
C 00000018 0050a223 sw   x5, 4(x1)
C 0000001c 40115313 srai x6, x2, 1
C 00000020 00415393 srli x7, x2, 4
C 00000024 00734433 xor  x8, x6, x7
C 00000028 0080a423 sw   x8, 8(x1)
C 0000002c 01c19493 slli x9, x3, 28
C 00000030 00312533 slt  x10, x2, x3
C 00000034 0021b5b3 sltu x11, x3, x2
C 00000038 00a4e633 or   x12, x9, x10
C 0000003c 00b606b3 add  x13, x12, x11
C 00000040 ff06f713 andi x14, x13, -16
C 00000044 00d0a623 sw   x13, 12(x1)
C 00000048 00e0a823 sw   x14, 16(x1)
C 0000004c 123457b7 lui  x15, 0x12345
C 00000050 00001817 auipc x16, 0x1
C 00000054 010788b3 add  x17, x15, x16
C 00000058 0110aa23 sw   x17, 20(x1)
C 0000005c 07b00013 addi x0, x0, 123
C 00000060 0000ac23 sw   x0, 24(x1)
C 00000064 0800a903 lw   x18, 0x80(x1)
C 00000068 0040a983 lw   x19, 4(x1)
C 0000006c 01390a33 add  x20, x18, x19
C 00000070 0140ae23 sw   x20, 28(x1)
C 00000074 00310463 beq  x2, x3, +8 not taken
C 00000078 001a8a93 addi x21, x21, 1
C 0000007c 00311463 bne  x2, x3, +8 taken
C 00000080 002a8a93 addi x21, x21, 2
C 00000084 00314463 blt  x2, x3, +8 taken
C 00000088 004a8a93 addi x21, x21, 4
C 0000008c 00315463 bge  x2, x3, +8 not taken
C 00000090 008a8a93 addi x21, x21, 8
C 00000094 00316463 bltu x2, x3, +8 not taken
C 00000098 010a8a93 addi x21, x21, 16
C 0000009c 00317463 bgeu x2, x3, +8 taken
C 000000a0 020a8a93 addi x21, x21, 32
C 000000a4 01328463 beq  x5, x19, +8 taken
C 000000a8 040a8a93 addi x21, x21, 64
C 000000ac 0350a023 sw   x21, 32(x1)
C 000000b0 00c00b6f jal  x22, +12
C 000000b4 040a8a93 addi x21, x21, 64
C 000000b8 040a8a93 addi x21, x21, 64
C 000000bc 0360a223 sw   x22, 36(x1)
C 000000c0 019b0be7 jalr x23, 0x19(x22)
C 000000c4 040a8a93 addi x21, x21, 64
C 000000c8 040a8a93 addi x21, x21, 64
C 000000cc 0370a423 sw   x23, 40(x1)
C 000000d0 0350a623 sw   x21, 44(x1)
C 000000d4 00000f8f fence with rd x31, runs as a no-op
C 000000d8 03f0a823 sw   x31, 48(x1)
C 000000dc 00000073 ecall
C 00000180 cafef00d preloaded data word
D 00000100 fffffffe -7 + 5
D 00000104 0000000c 5 - -7
D 00000108 f0000003 srai ^ srli
D 0000010c 50000002 (5 << 28 | slt) + sltu
D 00000110 50000000 andi with -16
D 00000114 12346050 lui + auipc
D 00000118 00000000 x0 after a write
D 0000011c cafef019 two loads added
D 00000120 00000019 branch markers
D 00000124 000000b4 jal link
D 00000128 000000c4 jalr link
D 0000012c 00000019 markers after the jumps
D 00000130 00000000 x31 untouched by the no-op
E end of trace

// ==== verilog/rv_alu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_macros.svh"

module rv_alu (
  rv_decode_if.alu            dec,
  input  logic [`RV_XLEN-1:0] pc,
  input  logic [`RV_XLEN-1:0] rs1_data,
  input  logic [`RV_XLEN-1:0] rs2_data,
  output logic [`RV_XLEN-1:0] result,
  output logic                branch_taken
);

  logic [`RV_XLEN-1:0] op_a, op_b;
  logic [4:0]          shamt;
  logic                lt, eq;

  assign op_a  = dec.use_pc ? pc : rs1_data;
  assign op_b  = dec.use_imm ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec.alu_op)
      `RV_ALU_SUB:  result = op_a - op_b;
      `RV_ALU_SLL:  result = op_a << shamt;
      `RV_ALU_SLT:  result = {31'b0, $signed(op_a) < $signed(op_b)};
      `RV_ALU_SLTU: result = {31'b0, op_a < op_b};
      `RV_ALU_XOR:  result = op_a ^ op_b;
      `RV_ALU_SRL:  result = op_a >> shamt;
      `RV_ALU_SRA:  result = $signed(op_a) >>> shamt;
      `RV_ALU_OR:   result = op_a | op_b;
      `RV_ALU_AND:  result = op_a & op_b;
      default:      result = op_a + op_b;
    endcase
  end

  // Branch compare always on rs1/rs2
  // funct3[2] picks less-than, [1] unsigned, [0] inverts
  assign eq = (rs1_data == rs2_data);
  assign lt = dec.branch_funct[1] ? (rs1_data < rs2_data)
                                  : ($signed(rs1_data) < $signed(rs2_data));

  assign branch_taken = dec.is_branch &&
                        ((dec.branch_funct[2] ? lt : eq) ^ dec.branch_funct[0]);

endmodule

`default_nettype wire

// ==== verilog/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  output logic        wb_cyc,
  output logic        wb_stb,
  output logic        wb_we,
  output logic [31:0] wb_adr,
  output logic [31:0] wb_wdata,
  input  logic [31:0] wb_rdata,
  input  logic        wb_ack,
  output logic        halt
);

  insn_t       insn;          // Instruction register to decoder
  logic [31:0] pc;
  logic [31:0] rs1_data, rs2_data;
  logic [31:0] alu_result;
  logic [31:0] rf_wdata;
  logic [4:0]  rf_waddr;
  logic        rf_we;
  logic        branch_taken;

  rv_decode_if dec_if ();

  rv_sequencer u_seq (.dec(dec_if), .*);

  rv_decoder u_dec (.dec(dec_if), .*);

  rv_regfile u_rf (
    .clk,
    .rst,
    .raddr1 (dec_if.rs1),
    .raddr2 (dec_if.rs2),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data),
    .we     (rf_we),
    .waddr  (rf_waddr),
    .wdata  (rf_wdata)
  );

  rv_alu u_alu (
    .dec          (dec_if),
    .pc,
    .rs1_data,
    .rs2_data,
    .result       (alu_result),
    .branch_taken
  );

endmodule

`default_nettype wire

// ==== verilog/rv_decode_if.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_macros.svh"

interface rv_decode_if;
  logic [`RV_REG_AW-1:0] rs1, rs2, rd;
  logic [`RV_XLEN-1:0]   imm;            // Already sign-extended
  logic [3:0]            alu_op;
  logic                  use_imm;        // Operand B select
  logic                  use_pc;         // Operand A select
  logic                  rf_we;
  logic                  is_branch;
  logic [2:0]            branch_funct;
  logic                  is_jal, is_jalr, is_load, is_store, is_halt;

  modport decoder (output rs1, rs2, rd, imm, alu_op, use_imm, use_pc, rf_we, is_branch,
                   branch_funct, is_jal, is_jalr, is_load, is_store, is_halt);

  modport sequencer (input rd, imm, rf_we, is_jal, is_jalr, is_load, is_store, is_halt);

  modport alu (input imm, alu_op, use_imm, use_pc, is_branch, branch_funct);
endinterface

`default_nettype wire

// ==== verilog/rv_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_macros.svh"

module rv_decoder import rv_pkg::*; (
  input  insn_t        insn,
  rv_decode_if.decoder dec
);

  logic [`RV_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic                shift;
  logic                alt_ok; // funct7 legal for this funct3

  assign opcode = insn.r_fmt.opcode;
  assign funct3 = insn.r_fmt.funct3;
  assign funct7 = insn.r_fmt.funct7;
  assign shift  = (funct3 == `RV_F3_SLL) || (funct3 == `RV_F3_SR);
  assign alt_ok = (funct7 == 7'b000_0000) ||
                  (funct7 == 7'b010_0000 && (funct3 == `RV_F3_ADD || funct3 == `RV_F3_SR));

  // Immediates, each from its own view of the word
  assign imm_i = {{20{insn.i_fmt.imm[11]}}, insn.i_fmt.imm};
  assign imm_s = {{20{insn.s_fmt.imm_hi[6]}}, insn.s_fmt.imm_hi, insn.s_fmt.imm_lo};
  assign imm_b = {{20{insn.b_fmt.imm_12}}, insn.b_fmt.imm_11, insn.b_fmt.imm_10_5,
                  insn.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {insn.u_fmt.imm, 12'b0};
  assign imm_j = {{12{insn.j_fmt.imm_20}}, insn.j_fmt.imm_19_12, insn.j_fmt.imm_11,
                  insn.j_fmt.imm_10_1, 1'b0};

  assign dec.rs1 = (opcode == `RV_OP_LUI) ? '0 : insn.r_fmt.rs1; // x0 gives LUI a zero A
  assign dec.rs2 = insn.r_fmt.rs2;
  assign dec.rd  = insn.r_fmt.rd;
  assign dec.branch_funct = funct3;

  assign dec.use_pc    = (opcode == `RV_OP_AUIPC);
  assign dec.use_imm   = (opcode != `RV_OP_OP);
  assign dec.is_jal    = (opcode == `RV_OP_JAL);
  assign dec.is_jalr   = (opcode == `RV_OP_JALR);
  assign dec.is_branch = (opcode == `RV_OP_BRANCH) && (funct3[2:1] != 2'b01);
  assign dec.is_load   = (opcode == `RV_OP_LOAD) && (funct3 == `RV_F3_W);
  assign dec.is_store  = (opcode == `RV_OP_STORE) && (funct3 == `RV_F3_W);
  assign dec.is_halt   = (opcode == `RV_OP_SYSTEM) && (insn[31:7] == '0); // ECALL

  // Only the shift pair and ADD/SUB use funct7[5]
  assign dec.alu_op = (opcode == `RV_OP_OP)     ? {funct7[5], funct3} :
                      (opcode == `RV_OP_OP_IMM) ? {funct3 == `RV_F3_SR && funct7[5], funct3} :
                      `RV_ALU_ADD;

  always_comb begin
    case (opcode)
      `RV_OP_LUI, `RV_OP_AUIPC: dec.imm = imm_u;
      `RV_OP_JAL:               dec.imm = imm_j;
      `RV_OP_BRANCH:            dec.imm = imm_b;
      `RV_OP_STORE:             dec.imm = imm_s;
      default:                  dec.imm = imm_i;
    endcase
  end

  always_comb begin
    case (opcode)
      `RV_OP_LUI, `RV_OP_AUIPC, `RV_OP_JAL, `RV_OP_JALR: dec.rf_we = 1'b1;
      `RV_OP_LOAD:   dec.rf_we = (funct3 == `RV_F3_W);
      `RV_OP_OP_IMM: dec.rf_we = !shift || alt_ok;
      `RV_OP_OP:     dec.rf_we = alt_ok;
      default:       dec.rf_we = 1'b0; // Unsupported encodings retire as no-ops
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/rv_pkg.sv ====
`default_nettype none
`include "rv_macros.svh"

package rv_pkg;

  // Base formats, msb first
  typedef struct packed {
    logic [6:0]            funct7;
    logic [`RV_REG_AW-1:0] rs2, rs1;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    logic [6:0]            opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]           imm;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    logic [6:0]            opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]            imm_hi; // imm[11:5]
    logic [`RV_REG_AW-1:0] rs2, rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm_lo;
    logic [6:0]            opcode;
  } s_fmt_t;

  typedef struct packed {
    logic                  imm_12;
    logic [5:0]            imm_10_5;
    logic [`RV_REG_AW-1:0] rs2, rs1;
    logic [2:0]            funct3;
    logic [3:0]            imm_4_1;
    logic                  imm_11;
    logic [6:0]            opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0]           imm; // imm[31:12]
    logic [`RV_REG_AW-1:0] rd;
    logic [6:0]            opcode;
  } u_fmt_t;

  typedef struct packed {
    logic                  imm_20;
    logic [9:0]            imm_10_1;
    logic                  imm_11;
    logic [7:0]            imm_19_12;
    logic [`RV_REG_AW-1:0] rd;
    logic [6:0]            opcode;
  } j_fmt_t;

  // One fetched word, every format view
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } insn_t;

endpackage

`default_nettype wire

// ==== verilog/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_macros.svh"

module rv_regfile (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`RV_REG_AW-1:0] raddr1,
  input  logic [`RV_REG_AW-1:0] raddr2,
  output logic [`RV_XLEN-1:0]   rdata1,
  output logic [`RV_XLEN-1:0]   rdata2,
  input  logic                  we,
  input  logic [`RV_REG_AW-1:0] waddr,
  input  logic [`RV_XLEN-1:0]   wdata
);

  logic [`RV_XLEN-1:0] regs [1:(1 << `RV_REG_AW)-1]; // No storage for x0

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < (1 << `RV_REG_AW); i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== verilog/rv_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_macros.svh"

module rv_sequencer import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  rv_decode_if.sequencer        dec,
  output insn_t                 insn,
  output logic [`RV_XLEN-1:0]   pc,
  input  logic [`RV_XLEN-1:0]   alu_result,
  input  logic                  branch_taken,
  input  logic [`RV_XLEN-1:0]   rs2_data,
  output logic                  rf_we,
  output logic [`RV_REG_AW-1:0] rf_waddr,
  output logic [`RV_XLEN-1:0]   rf_wdata,
  output logic                  wb_cyc,
  output logic                  wb_stb,
  output logic                  wb_we,
  output logic [`RV_XLEN-1:0]   wb_adr,
  output logic [`RV_XLEN-1:0]   wb_wdata,
  input  logic [`RV_XLEN-1:0]   wb_rdata,
  input  logic                  wb_ack,
  output logic                  halt
);

  localparam logic [1:0] st_fetch  = 2'd0;
  localparam logic [1:0] st_exec   = 2'd1;
  localparam logic [1:0] st_mem    = 2'd2;
  localparam logic [1:0] st_halted = 2'd3;

  logic [1:0]          state;
  logic [`RV_XLEN-1:0] pc_plus4, pc_target, pc_next;
  logic                mem_op;

  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + dec.imm; // Branch and JAL target
  assign mem_op    = dec.is_load || dec.is_store;
  assign pc_next   = (dec.is_jal || branch_taken) ? pc_target :
                     dec.is_jalr ? {alu_result[`RV_XLEN-1:1], 1'b0} : pc_plus4;

  // Results land in EXEC, load data on the MEM ack edge
  assign rf_waddr = dec.rd;
  assign rf_we    = (state == st_exec && dec.rf_we && !dec.is_load) ||
                    (state == st_mem && wb_ack && dec.is_load);
  assign rf_wdata = (state == st_mem) ? wb_rdata :
                    (dec.is_jal || dec.is_jalr) ? pc_plus4 : alu_result;

  assign wb_stb = wb_cyc; // Single-beat classic cycles
  assign halt   = (state == st_halted);

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= st_fetch;
      pc     <= `RV_RESET_PC;
      wb_cyc <= 1'b0;
      wb_we  <= 1'b0;
    end else begin
      case (state)
        st_fetch: begin
          if (!wb_cyc) begin
            wb_cyc <= 1'b1;          // Idle entry, start the fetch
          end else if (wb_ack) begin
            wb_cyc <= 1'b0;
            state  <= st_exec;
          end
        end
        st_exec: begin
          if (dec.is_halt) begin
            state <= st_halted;
          end else if (mem_op) begin
            wb_cyc <= 1'b1;
            wb_we  <= dec.is_store;
            state  <= st_mem;
          end else begin
            pc     <= pc_next;
            wb_cyc <= 1'b1;          // Next fetch goes out straight away
            state  <= st_fetch;
          end
        end
        st_mem: begin
          if (wb_ack) begin
            wb_cyc <= 1'b0;
            wb_we  <= 1'b0;
            pc     <= pc_plus4;
            state  <= st_fetch;
          end
        end
        default: ; // Stay halted until reset
      endcase
    end
  end

  // Instruction register and bus payload
  always_ff @(posedge clk) begin
    if (state == st_fetch && wb_cyc && wb_ack) begin
      insn <= wb_rdata;
    end
    if (state == st_fetch && !wb_cyc) begin
      wb_adr <= pc;
    end else if (state == st_exec) begin
      wb_adr   <= mem_op ? alu_result : pc_next;
      wb_wdata <= rs2_data;
    end
  end

endmodule

`default_nettype wire
